// File: files.f
source/cpu_ctrl_pkg.sv
source/opcode_decode.sv
source/instr_reg.sv
source/cycle_sequencer.sv
source/ctrl_strobes.sv
source/decoding_unit.sv
sim/decoding_unit_asserts.sv
sim/ctrl_monitor.sv
sim/tb_decoding_unit.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the decoding unit testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim_run.log

verilator --binary --timing --assert -f files.f --top-module tb_decoding_unit -Mdir obj_dir
./obj_dir/Vtb_decoding_unit +verilator+error+limit+100 | tee "$LOG"

if grep -qx "Done: no errors" "$LOG"; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi

// File: sim/ctrl_monitor.sv
/* Control strobe checker */
`timescale 1ns/10ps

module ctrl_monitor #(
	parameter int MAX_LINES = 64
) (
	input logic phi1,
	input logic reset,
	input logic ale,
	input logic rd_n,
	input logic wr_n,
	input logic mem_req,
	input cpu_ctrl_pkg::mc_t mc,
	input cpu_ctrl_pkg::t_state_t t_state,
	input logic reg_rd,
	input cpu_ctrl_pkg::reg_sel_t reg_rd_sel,
	input logic reg_wr,
	input cpu_ctrl_pkg::reg_sel_t reg_wr_sel,
	input logic pc_inc,
	input logic addr_from_hl,
	input logic xchg,
	input logic [71:0] trace [0:MAX_LINES-1],
	input int line_count,
	output logic done,
	output int errors,
	output int checked
);
	import cpu_ctrl_pkg::*;

	localparam logic [7:0] NONE = 8'hFF;
	localparam int HALT_IDLE_CYCLES = 20;

	int instr_idx;
	int idle_count;
	logic active;
	logic halted;
	logic req_prev;
	int n_reads;
	int n_writes;
	int n_rd;
	int n_wr;
	int n_xchg;
	int n_pc;
	int n_hl;
	int n_t1;
	int n_t4;
	logic [7:0] rd_sel_seen;
	logic [7:0] wr_sel_seen [0:1];

	function automatic int compare_byte(input string name, input logic [7:0] expected,
		input logic [7:0] actual);
		if (expected !== actual) begin
			$display("MISMATCH instr %0d %s: expected %02h got %02h", instr_idx, name,
				expected, actual);
			return 1;
		end
		return 0;
	endfunction

	task automatic start_instr();
		instr_idx++;
		active = 1'b1;
		n_reads = 0;
		n_writes = 0;
		n_rd = 0;
		n_wr = 0;
		n_xchg = 0;
		n_pc = 0;
		n_hl = 0;
		n_t1 = 0;
		n_t4 = 0;
		rd_sel_seen = NONE;
		wr_sel_seen[0] = NONE;
		wr_sel_seen[1] = NONE;
	endtask

	task automatic close_instr();
		logic [71:0] exp;
		int bad;
		int wr_expected;
		bad = 0;
		if (instr_idx >= line_count) begin
			$display("Instruction %0d fetched beyond the %0d trace lines", instr_idx, line_count);
			errors++;
		end else begin
			exp = trace[instr_idx];
			wr_expected = int'(exp[39:32] != NONE) + int'(exp[31:24] != NONE);
			bad += compare_byte("read requests", exp[63:56], 8'(n_reads));
			bad += compare_byte("write requests", exp[55:48], 8'(n_writes));
			bad += compare_byte("reg_rd pulses", (exp[47:40] == NONE) ? 8'h00 : 8'h01, 8'(n_rd));
			bad += compare_byte("reg_rd_sel", exp[47:40], rd_sel_seen);
			bad += compare_byte("reg_wr pulses", 8'(wr_expected), 8'(n_wr));
			bad += compare_byte("reg_wr_sel first", exp[39:32], wr_sel_seen[0]);
			bad += compare_byte("reg_wr_sel second", exp[31:24], wr_sel_seen[1]);
			bad += compare_byte("xchg", exp[23:16], 8'(n_xchg));
			bad += compare_byte("pc_inc", exp[15:8], 8'(n_pc));
			bad += compare_byte("addr_from_hl", exp[7:0], 8'(n_hl));
			// One T1 per machine cycle, one T4 in M1 only
			bad += compare_byte("t_state T1 cycles", exp[63:56] + exp[55:48], 8'(n_t1));
			bad += compare_byte("t_state T4 cycles", 8'h01, 8'(n_t4));
			if (bad == 0)
				$display("PASS instr %0d op %02h", instr_idx, exp[71:64]);
			else
				$display("FAIL instr %0d op %02h with %0d mismatches", instr_idx, exp[71:64], bad);
			errors += bad;
		end
		checked++;
	endtask

	always @(negedge phi1) begin
		if (reset) begin
			instr_idx = -1;
			active = 1'b0;
			halted = 1'b0;
			idle_count = 0;
			done = 1'b0;
			errors = 0;
			checked = 0;
		end else if (halted) begin
			if (!done && (ale || mem_req)) begin
				$display("Bus activity in halt at idle cycle %0d", idle_count);
				errors++;
			end
			idle_count++;
			if (!done && idle_count == HALT_IDLE_CYCLES) begin
				$display("Halt idle check finished after %0d cycles", idle_count);
				done = 1'b1;
			end
		end else begin
			if (ale && mc == MC_M1) begin	// Next fetch closes the last instruction
				if (active)
					close_instr();
				start_instr();
			end
			if (active) begin
				if (mem_req && !req_prev) begin
					if (!rd_n)
						n_reads++;
					else if (!wr_n)
						n_writes++;
					else begin
						$display("Request in instr %0d with neither rd_n nor wr_n low", instr_idx);
						errors++;
					end
				end
				if (reg_rd) begin
					n_rd++;
					rd_sel_seen = {5'b0, reg_rd_sel};
				end
				if (reg_wr) begin
					if (n_wr < 2)
						wr_sel_seen[n_wr] = {5'b0, reg_wr_sel};
					n_wr++;
				end
				if (xchg)
					n_xchg++;
				if (pc_inc)
					n_pc++;
				if (addr_from_hl)
					n_hl++;
				if (t_state == T1)
					n_t1++;
				if (t_state == T4)
					n_t4++;
			end
			if (mc == MC_HALT) begin
				if (active)
					close_instr();
				if (instr_idx + 1 != line_count) begin
					$display("Halt reached at instr %0d but trace has %0d lines", instr_idx,
						line_count);
					errors++;
				end
				active = 1'b0;
				halted = 1'b1;
			end
		end
		req_prev = mem_req;
	end

endmodule

// File: sim/decode_trace.txt
# op reads writes reg_rd_sel reg_wr_sel1 reg_wr_sel2 xchg pc_inc addr_from_hl
# hex, counts per instruction, FF means no strobe
41 01 00 01 00 FF 00 01 00
7B 01 00 03 07 FF 00 01 00
65 01 00 05 04 FF 00 01 00
3E 02 00 FF 07 FF 00 02 00
0E 02 00 FF 01 FF 00 02 00
56 02 00 FF 02 FF 00 01 01
7E 02 00 FF 07 FF 00 01 01
01 03 00 FF 01 00 00 03 00
11 03 00 FF 03 02 00 03 00
21 03 00 FF 05 04 00 03 00
31 03 00 FF FF FF 00 03 00
70 01 01 00 FF FF 00 01 01
77 01 01 07 FF FF 00 01 01
EB 01 00 FF FF FF 01 01 00
00 01 00 FF FF FF 00 01 00
80 01 00 FF FF FF 00 01 00
C3 01 00 FF FF FF 00 01 00
36 01 00 FF FF FF 00 01 00
09 01 00 FF FF FF 00 01 00
5A 01 00 02 03 FF 00 01 00
6E 02 00 FF 05 FF 00 01 01
76 01 00 FF FF FF 00 01 00

// File: sim/decoding_unit_asserts.sv
/* Handshake and strobe assertions */
`timescale 1ns/10ps

module decoding_unit_asserts (
	input logic phi1,
	input logic reset,
	input logic mem_req,
	input logic mem_ack,
	input logic rd_n,
	input logic wr_n,
	input logic reg_rd,
	input logic reg_wr
);
	int fail_count = 0;

	// Request held until the memory answers
	req_held: assert property (@(posedge phi1) disable iff (reset)
		mem_req && !mem_ack |=> mem_req)
	else begin
		$error("mem_req dropped before mem_ack");
		fail_count++;
	end

	req_released: assert property (@(posedge phi1) disable iff (reset)
		mem_req && mem_ack |=> !mem_req)
	else begin
		$error("mem_req still high after mem_ack");
		fail_count++;
	end

	strobes_exclusive: assert property (@(posedge phi1) disable iff (reset)
		rd_n || wr_n)
	else begin
		$error("rd_n and wr_n both low");
		fail_count++;
	end

	reg_rd_single: assert property (@(posedge phi1) disable iff (reset)
		reg_rd |=> !reg_rd)
	else begin
		$error("reg_rd longer than one cycle");
		fail_count++;
	end

	reg_wr_single: assert property (@(posedge phi1) disable iff (reset)
		reg_wr |=> !reg_wr)
	else begin
		$error("reg_wr longer than one cycle");
		fail_count++;
	end

endmodule

// File: sim/tb_decoding_unit.sv
/* Decoding unit testbench */
`timescale 1ns/10ps

module tb_decoding_unit;
	import cpu_ctrl_pkg::*;

	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 3;
	localparam int MAX_LINES = 64;
	localparam int CYCLES_PER_LINE = 40;
	localparam int TIMEOUT_BASE = 50;
	localparam logic [31:0] LCG_SEED = 32'h8cd0;

	logic phi1;
	logic reset;
	data_t data_in;
	logic mem_ack;
	logic ale;
	logic rd_n;
	logic wr_n;
	logic mem_req;
	mc_t mc;
	t_state_t t_state;
	logic reg_rd;
	reg_sel_t reg_rd_sel;
	logic reg_wr;
	reg_sel_t reg_wr_sel;
	logic pc_inc;
	logic addr_from_hl;
	logic xchg;

	logic [71:0] trace [0:MAX_LINES-1];	// op reads writes rd wr1 wr2 xchg pc hl
	int line_count = 0;
	logic trace_ok;
	int fetch_idx = 0;
	int cycle_count = 0;
	int timeout_limit;
	logic mon_done;
	int mon_errors;
	int mon_checked;

	decoding_unit i_decoding_unit (.*);

	bind decoding_unit decoding_unit_asserts i_asserts (
		.phi1(phi1),
		.reset(reset),
		.mem_req(mem_req),
		.mem_ack(mem_ack),
		.rd_n(rd_n),
		.wr_n(wr_n),
		.reg_rd(reg_rd),
		.reg_wr(reg_wr)
	);

	ctrl_monitor #(.MAX_LINES(MAX_LINES)) i_ctrl_monitor (
		.phi1(phi1), .reset(reset), .ale(ale), .rd_n(rd_n), .wr_n(wr_n),
		.mem_req(mem_req), .mc(mc), .t_state(t_state),
		.reg_rd(reg_rd), .reg_rd_sel(reg_rd_sel),
		.reg_wr(reg_wr), .reg_wr_sel(reg_wr_sel), .pc_inc(pc_inc),
		.addr_from_hl(addr_from_hl), .xchg(xchg), .trace(trace), .line_count(line_count),
		.done(mon_done), .errors(mon_errors), .checked(mon_checked)
	);

	function automatic logic [31:0] lcg_step(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic load_trace();
		int fd;
		int n;
		string text;
		logic [7:0] op, rds, wrs, rsel, wr1, wr2, xc, pc, hl;
		for (int i = 0; i < MAX_LINES; i++)
			trace[i] = '0;
		trace_ok = 1'b0;
		fd = $fopen("sim/decode_trace.txt", "r");
		if (fd == 0) begin
			$display("Cannot open trace file sim/decode_trace.txt");
		end else begin
			while ($fgets(text, fd) != 0) begin
				n = $sscanf(text, "%h %h %h %h %h %h %h %h %h", op, rds, wrs, rsel, wr1, wr2,
					xc, pc, hl);
				if (n == 9) begin	// Comment and blank lines fall through
					if (line_count < MAX_LINES)
						trace[line_count] = {op, rds, wrs, rsel, wr1, wr2, xc, pc, hl};
					line_count++;
				end
			end
			$fclose(fd);
			if (line_count == 0 || line_count > MAX_LINES)
				$display("Trace holds %0d lines, expected 1 to %0d", line_count, MAX_LINES);
			else
				trace_ok = 1'b1;
		end
	endtask

	initial begin : clock_gen
		phi1 = 1'b0;
		forever #(CLK_PERIOD / 2) phi1 = ~phi1;
	end

	always @(posedge phi1)
		cycle_count <= cycle_count + 1;

	// Memory side of the handshake
	initial begin : memory_model
		int wait_cycles;
		logic fetch;
		logic reading;
		logic [31:0] rand_state;
		rand_state = LCG_SEED;
		mem_ack <= 1'b0;
		data_in <= 8'h00;
		forever begin
			@(posedge phi1);
			if (!reset && mem_req && !mem_ack) begin
				fetch = (mc == MC_M1);
				reading = !rd_n;
				rand_state = lcg_step(rand_state);
				wait_cycles = int'(rand_state[25:24]);
				repeat (wait_cycles) @(posedge phi1);
				if (fetch) begin
					data_in <= (fetch_idx < line_count) ? trace[fetch_idx][71:64] : 8'h00;
					fetch_idx++;
				end else if (reading) begin
					rand_state = lcg_step(rand_state);
					data_in <= rand_state[23:16];
				end
				mem_ack <= 1'b1;
			end else if (mem_ack && !mem_req) begin
				rand_state = lcg_step(rand_state);
				wait_cycles = int'(rand_state[25:24]);
				repeat (wait_cycles) @(posedge phi1);
				mem_ack <= 1'b0;
			end
		end
	end

	initial begin : main
		int assert_fails;
		reset <= 1'b1;
		load_trace();
		timeout_limit = CYCLES_PER_LINE * line_count + TIMEOUT_BASE;
		repeat (RESET_CYCLES) @(posedge phi1);
		reset <= 1'b0;
		while (trace_ok && !mon_done && cycle_count < timeout_limit)
			@(posedge phi1);
		assert_fails = i_decoding_unit.i_asserts.fail_count;
		if (!trace_ok) begin
			$display("Run stopped, no usable trace");
			$display("Done: errors found");
		end else if (!mon_done) begin
			$display("Timeout after %0d cycles without reaching halt", cycle_count);
			$display("Done: errors found");
		end else begin
			$display("Summary: %0d instructions checked, %0d errors, %0d assertion failures",
				mon_checked, mon_errors, assert_fails);
			if (mon_errors == 0 && assert_fails == 0)
				$display("Done: no errors");
			else
				$display("Done: errors found");
		end
		$finish;
	end

endmodule

// File: source/cpu_ctrl_pkg.sv
/* CPU control unit definitions */
package cpu_ctrl_pkg;

	// Bus and instruction bytes
	typedef logic [7:0] opcode_t;
	typedef logic [7:0] data_t;

	// Register code B C D E H L M A
	typedef logic [2:0] reg_sel_t;

	// Data reads after the opcode fetch (0 to 2)
	typedef logic [1:0] rd_count_t;

	localparam reg_sel_t REG_M = 3'd6;	// Memory through HL

	localparam opcode_t OP_XCHG = 8'hEB;
	localparam opcode_t OP_HLT = 8'h76;

	// Field positions in the opcode
	localparam int DST_LSB = 3;	// ddd
	localparam int SRC_LSB = 0;	// sss
	localparam int RP_LSB = 4;	// rp of LXI

	// Kept instruction groups plus G_NOP for the rest
	typedef enum logic [2:0] {
		G_NOP,
		G_MOV_RR,
		G_MOV_RM,	// MOV r,M
		G_MOV_MR,	// MOV M,r
		G_MVI,
		G_LXI,
		G_XCHG,
		G_HLT
	} op_group_t;

	// Machine cycles
	typedef enum logic [2:0] {
		MC_M1,
		MC_R1,
		MC_R2,
		MC_W1,
		MC_HALT
	} mc_t;

	// T-states without T5 or T6
	typedef enum logic [2:0] {
		T_RESET,
		T1,
		T2,
		T3,
		T4
	} t_state_t;

endpackage

// File: source/ctrl_strobes.sv
/* Register file control strobes */
`timescale 1ns/10ps

module ctrl_strobes (
	input logic phi1,
	input logic reset,
	input cpu_ctrl_pkg::mc_t mc,
	input cpu_ctrl_pkg::t_state_t t_state,
	input cpu_ctrl_pkg::op_group_t group,
	input cpu_ctrl_pkg::reg_sel_t dst_sel,
	input cpu_ctrl_pkg::reg_sel_t src_sel,
	output logic reg_rd,
	output cpu_ctrl_pkg::reg_sel_t reg_rd_sel,
	output logic reg_wr,
	output cpu_ctrl_pkg::reg_sel_t reg_wr_sel,
	output logic pc_inc,
	output logic addr_from_hl,
	output logic xchg
);
	import cpu_ctrl_pkg::*;

	t_state_t t_prev;
	logic at_t1;
	logic at_t3;
	logic at_t4;
	logic [1:0] rp;
	logic lxi_pair;	// LXI to B, D or H

	always_ff @(posedge phi1) begin
		if (reset)
			t_prev <= T_RESET;
		else
			t_prev <= t_state;
	end

	// First cycle of each state
	assign at_t1 = (t_state == T1) && (t_prev != T1);
	assign at_t3 = (t_state == T3) && (t_prev != T3);
	assign at_t4 = (t_state == T4) && (t_prev != T4);

	assign rp = dst_sel[RP_LSB - DST_LSB +: 2];
	assign lxi_pair = (group == G_LXI) && (rp != 2'b11);

	assign pc_inc = at_t3 && ((mc == MC_M1) ||
		((mc == MC_R1 || mc == MC_R2) && group != G_MOV_RM));	// HL read leaves PC alone

	assign addr_from_hl = at_t1 && (((mc == MC_R1) && (group == G_MOV_RM)) ||
		((mc == MC_W1) && (group == G_MOV_MR)));

	// Source read once the opcode is latched
	assign reg_rd = at_t3 && (mc == MC_M1) &&
		(group == G_MOV_RR || group == G_MOV_MR);
	assign reg_rd_sel = src_sel;

	always_comb begin
		reg_wr = 1'b0;
		reg_wr_sel = dst_sel;
		if (at_t4 && mc == MC_M1 && group == G_MOV_RR)
			reg_wr = 1'b1;
		if (at_t3 && mc == MC_R1 && (group == G_MVI || group == G_MOV_RM))
			reg_wr = 1'b1;
		if (at_t3 && lxi_pair) begin
			if (mc == MC_R1) begin
				reg_wr = 1'b1;
				reg_wr_sel = {rp, 1'b1};	// C, E or L
			end else if (mc == MC_R2) begin
				reg_wr = 1'b1;
				reg_wr_sel = {rp, 1'b0};
			end
		end
	end

	assign xchg = at_t4 && (mc == MC_M1) && (group == G_XCHG);

endmodule

// File: source/cycle_sequencer.sv
/* Machine cycle and T-state sequencer */
`timescale 1ns/10ps

module cycle_sequencer (
	input logic phi1,
	input logic reset,
	input logic mem_ack,
	input cpu_ctrl_pkg::rd_count_t rd_count,
	input logic has_write,
	input logic is_halt,
	output cpu_ctrl_pkg::mc_t mc,
	output cpu_ctrl_pkg::t_state_t t_state,
	output logic fetch_done,
	output logic ale,
	output logic rd_n,
	output logic wr_n,
	output logic mem_req
);
	import cpu_ctrl_pkg::*;

	mc_t mc_next;
	rd_count_t rd_seen;	// R cycles done in this instruction
	logic rd_last;

	assign rd_last = (rd_seen + 2'd1) >= rd_count;

	// Next machine cycle at the end of T3 or T4
	always_comb begin
		mc_next = MC_M1;
		case (mc)
			MC_M1: begin
				if (is_halt)
					mc_next = MC_HALT;
				else if (rd_count != 2'd0)
					mc_next = MC_R1;
				else if (has_write)
					mc_next = MC_W1;
			end
			MC_R1, MC_R2: begin
				if (!rd_last)
					mc_next = MC_R2;
				else if (has_write)
					mc_next = MC_W1;
			end
			MC_HALT: mc_next = MC_HALT;
			default: mc_next = MC_M1;
		endcase
	end

	always_ff @(posedge phi1) begin
		if (reset) begin
			mc <= MC_M1;
			t_state <= T_RESET;
			rd_seen <= 2'd0;
		end else if (mc != MC_HALT) begin
			case (t_state)
				T_RESET: t_state <= T1;
				T1: t_state <= T2;
				T2: begin
					if (mem_ack)
						t_state <= T3;
				end
				T3: begin
					// Wait for the acknowledge to drop
					if (!mem_ack) begin
						if (mc == MC_M1) begin
							t_state <= T4;
						end else begin
							t_state <= T1;
							mc <= mc_next;
							if (mc == MC_R1 || mc == MC_R2)
								rd_seen <= rd_seen + 2'd1;
						end
					end
				end
				T4: begin
					// HALT idles with no T1
					t_state <= is_halt ? T_RESET : T1;
					mc <= mc_next;
					rd_seen <= 2'd0;
				end
				default: t_state <= T_RESET;
			endcase
		end
	end

	assign fetch_done = (mc == MC_M1) && (t_state == T2) && mem_ack;	// Opcode on data_in

	assign ale = (t_state == T1);
	assign mem_req = (t_state == T2);
	assign rd_n = !((t_state == T2) && (mc != MC_W1));
	assign wr_n = !((t_state == T2) && (mc == MC_W1));

endmodule

// File: source/decoding_unit.sv
/* Decoding unit top */
`timescale 1ns/10ps

module decoding_unit (
	input logic phi1,
	input logic reset,
	input cpu_ctrl_pkg::data_t data_in,
	input logic mem_ack,
	output logic ale,
	output logic rd_n,
	output logic wr_n,
	output logic mem_req,
	output cpu_ctrl_pkg::mc_t mc,
	output cpu_ctrl_pkg::t_state_t t_state,
	output logic reg_rd,
	output cpu_ctrl_pkg::reg_sel_t reg_rd_sel,
	output logic reg_wr,
	output cpu_ctrl_pkg::reg_sel_t reg_wr_sel,
	output logic pc_inc,
	output logic addr_from_hl,
	output logic xchg
);
	import cpu_ctrl_pkg::*;

	op_group_t group_dec;
	rd_count_t rd_count_dec;
	logic has_write_dec;
	op_group_t group;
	rd_count_t rd_count;
	logic has_write;
	logic is_halt;
	reg_sel_t dst_sel;
	reg_sel_t src_sel;
	logic fetch_done;

	opcode_decode i_opcode_decode (
		.opcode(data_in),
		.group(group_dec),
		.rd_count(rd_count_dec),
		.has_write(has_write_dec)
	);

	instr_reg i_instr_reg (
		.phi1(phi1),
		.reset(reset),
		.fetch_done(fetch_done),
		.opcode_in(data_in),
		.group_in(group_dec),
		.rd_count_in(rd_count_dec),
		.has_write_in(has_write_dec),
		.group(group),
		.rd_count(rd_count),
		.has_write(has_write),
		.is_halt(is_halt),
		.dst_sel(dst_sel),
		.src_sel(src_sel)
	);

	cycle_sequencer i_cycle_sequencer (
		.phi1(phi1),
		.reset(reset),
		.mem_ack(mem_ack),
		.rd_count(rd_count),
		.has_write(has_write),
		.is_halt(is_halt),
		.mc(mc),
		.t_state(t_state),
		.fetch_done(fetch_done),
		.ale(ale),
		.rd_n(rd_n),
		.wr_n(wr_n),
		.mem_req(mem_req)
	);

	ctrl_strobes i_ctrl_strobes (
		.phi1(phi1),
		.reset(reset),
		.mc(mc),
		.t_state(t_state),
		.group(group),
		.dst_sel(dst_sel),
		.src_sel(src_sel),
		.reg_rd(reg_rd),
		.reg_rd_sel(reg_rd_sel),
		.reg_wr(reg_wr),
		.reg_wr_sel(reg_wr_sel),
		.pc_inc(pc_inc),
		.addr_from_hl(addr_from_hl),
		.xchg(xchg)
	);

endmodule

// File: source/instr_reg.sv
/* Instruction register */
`timescale 1ns/10ps

module instr_reg (
	input logic phi1,
	input logic reset,
	input logic fetch_done,
	input cpu_ctrl_pkg::opcode_t opcode_in,
	input cpu_ctrl_pkg::op_group_t group_in,
	input cpu_ctrl_pkg::rd_count_t rd_count_in,
	input logic has_write_in,
	output cpu_ctrl_pkg::op_group_t group,
	output cpu_ctrl_pkg::rd_count_t rd_count,
	output logic has_write,
	output logic is_halt,
	output cpu_ctrl_pkg::reg_sel_t dst_sel,
	output cpu_ctrl_pkg::reg_sel_t src_sel
);
	import cpu_ctrl_pkg::*;

	always_ff @(posedge phi1) begin
		if (reset) begin
			group <= G_NOP;
			rd_count <= 2'd0;
			has_write <= 1'b0;
		end else if (fetch_done) begin
			group <= group_in;
			rd_count <= rd_count_in;
			has_write <= has_write_in;
		end
	end

	// Register fields
	always_ff @(posedge phi1) begin
		if (fetch_done) begin
			dst_sel <= opcode_in[DST_LSB +: 3];
			src_sel <= opcode_in[SRC_LSB +: 3];
		end
	end

	assign is_halt = (group == G_HLT);

endmodule

// File: source/opcode_decode.sv
/* Opcode group decoder */
`timescale 1ns/10ps

module opcode_decode (
	input cpu_ctrl_pkg::opcode_t opcode,
	output cpu_ctrl_pkg::op_group_t group,
	output cpu_ctrl_pkg::rd_count_t rd_count,
	output logic has_write
);
	import cpu_ctrl_pkg::*;

	reg_sel_t dst;
	reg_sel_t src;

	assign dst = opcode[DST_LSB +: 3];
	assign src = opcode[SRC_LSB +: 3];

	always_comb begin
		group = G_NOP;
		if (opcode == OP_HLT) begin
			group = G_HLT;	// Would otherwise be MOV M,M
		end else if (opcode == OP_XCHG) begin
			group = G_XCHG;
		end else if (opcode[7:6] == 2'b01) begin
			if (dst == REG_M)
				group = G_MOV_MR;
			else if (src == REG_M)
				group = G_MOV_RM;
			else
				group = G_MOV_RR;
		end else if (opcode[7:6] == 2'b00) begin
			// MVI M left out
			if (src == REG_M && dst != REG_M)
				group = G_MVI;
			else if (opcode[3:0] == 4'b0001)
				group = G_LXI;
		end
	end

	// Bus-cycle plan per group
	always_comb begin
		rd_count = 2'd0;
		has_write = 1'b0;
		case (group)
			G_MOV_RM, G_MVI: rd_count = 2'd1;
			G_LXI: rd_count = 2'd2;	// Low byte then high byte
			G_MOV_MR: has_write = 1'b1;
			default: begin
				rd_count = 2'd0;
				has_write = 1'b0;
			end
		endcase
	end

endmodule
